//--- acc_fifo.sv
// Show-ahead FIFO, DEPTH a power of two; a write into a full FIFO is dropped and flagged sticky
`timescale 1ns/10ps

module acc_fifo #(
    parameter int DEPTH = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    acc_if.dst   wr,
    acc_if.src   rd,
    output logic overflow
);
    import tcu_norm_pkg::*;

    localparam int AW    = $clog2(DEPTH);
    // Accumulator, exponent and the four flags
    localparam int REC_W = WA + BEXP_W + 4;

    logic [REC_W-1:0] mem [DEPTH];
    logic [REC_W-1:0] wr_rec;
    logic [REC_W-1:0] head;
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);
    // Full FIFO refuses the write even if a pop happens in the same cycle
    assign push  = wr.valid && !full;
    assign pop   = !stall && !empty;

    assign wr_rec = {wr.acc, wr.bexp, wr.is_int, wr.nan, wr.inf, wr.inf_sign};

    // ==============================
    // Storage
    // ==============================

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

    // Head is visible without a read cycle
    assign head     = mem[rd_ptr];
    assign rd.valid = pop;
    assign {rd.acc, rd.bexp, rd.is_int, rd.nan, rd.inf, rd.inf_sign} = head;

    // ==============================
    // Pointers, count, overflow
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (wr.valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= (AW+1)'(DEPTH));

    // Stall holds the records, nothing leaves
    a_no_rd_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !rd.valid);

endmodule

//--- acc_if.sv
// One accumulator record per cycle; valid is a single-cycle strobe with no back-pressure
`timescale 1ns/10ps

interface acc_if;
    import tcu_norm_pkg::*;

    // Record strobe
    logic  valid;
    // Sign-magnitude sum, sign in the top bit
    acc_t  acc;
    // Block exponent of the request
    bexp_t bexp;
    // Request flags
    logic  is_int;
    logic  nan;
    logic  inf;
    logic  inf_sign;

    // Stage that produces the record
    modport src (
        output valid, acc, bexp, is_int, nan, inf, inf_sign
    );

    // Stage that takes the record
    modport dst (
        input valid, acc, bexp, is_int, nan, inf, inf_sign
    );

endinterface

//--- fedp_accum.sv
// Sum of four 14-bit signed products is exact; result is registered one cycle after in_valid
`timescale 1ns/10ps

module fedp_accum (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  tcu_norm_pkg::opnd_t a0,
    input  tcu_norm_pkg::opnd_t a1,
    input  tcu_norm_pkg::opnd_t a2,
    input  tcu_norm_pkg::opnd_t a3,
    input  tcu_norm_pkg::opnd_t b0,
    input  tcu_norm_pkg::opnd_t b1,
    input  tcu_norm_pkg::opnd_t b2,
    input  tcu_norm_pkg::opnd_t b3,
    input  tcu_norm_pkg::bexp_t in_bexp,
    input  logic                in_is_int,
    input  logic                in_nan,
    input  logic                in_inf,
    input  logic                in_inf_sign,
    acc_if.src                  out
);
    import tcu_norm_pkg::*;

    opnd_t              a_vec [N_PAIRS];
    opnd_t              b_vec [N_PAIRS];
    logic signed [WA-1:0] sum_c;
    logic                 sum_neg;
    logic [WA-1:0]        sum_abs;

    assign a_vec[0] = a0;
    assign a_vec[1] = a1;
    assign a_vec[2] = a2;
    assign a_vec[3] = a3;
    assign b_vec[0] = b0;
    assign b_vec[1] = b1;
    assign b_vec[2] = b2;
    assign b_vec[3] = b3;

    // ==============================
    // Exact products and sum
    // ==============================

    // 28-bit signed products, sign-extended into the 30-bit sum
    always_comb begin
        logic signed [2*OPND_W-1:0] prod;
        sum_c = '0;
        for (int i = 0; i < N_PAIRS; i++) begin
            prod  = a_vec[i] * b_vec[i];
            sum_c = sum_c + prod;
        end
    end

    // Two's complement to sign-magnitude
    assign sum_neg = sum_c[WA-1];
    assign sum_abs = sum_neg ? (~sum_c + 1'b1) : sum_c;

    // ==============================
    // Record register
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;
        end
    end

    // Payload only loads on a request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out.acc      <= {sum_neg, sum_abs[WA-2:0]};
            out.bexp     <= in_bexp;
            out.is_int   <= in_is_int;
            out.nan      <= in_nan;
            out.inf      <= in_inf;
            out.inf_sign <= in_inf_sign;
        end
    end

    // Worst case is 4 * (-2^13)^2 = 2^28, so bit 29 of the magnitude stays clear
    a_mag_range: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !sum_abs[WA-1]);

endmodule

//--- fedp_norm_round.sv
// fp32 round to nearest even with flush to zero and no denormals; integer mode sign-extends
`timescale 1ns/10ps

module fedp_norm_round (
    input  logic                  clk,
    input  logic                  rst_n,
    acc_if.dst                    in,
    output logic                  result_valid,
    output tcu_norm_pkg::result_t result
);
    import tcu_norm_pkg::*;

    // Magnitude width below the sign bit
    localparam int MW    = WA - 1;
    // Hidden one plus 23 fraction bits
    localparam int MAN_W = 24;

    logic             sum_sign;
    logic [MW-1:0]    mag;
    logic             zero_sum;
    logic [LZC_W-1:0] lz;
    logic [MW-1:0]    norm;
    logic [MAN_W-1:0] man;
    logic             guard_bit;
    logic             sticky_bit;
    logic             round_up;
    logic [MAN_W:0]   man_rnd;
    logic             carry;
    logic [22:0]      frac;
    exp_t             norm_exp;
    exp_t             final_exp;
    result_t          fp_res;
    logic [WA-1:0]    int_sum;
    result_t          int_res;

    // Counts leading zeros of the magnitude and gives MW for an all-zero input
    function automatic logic [LZC_W-1:0] lzc(input logic [MW-1:0] v);
        logic [LZC_W-1:0] n;
        logic             found;
        n     = '0;
        found = 1'b0;
        for (int i = MW - 1; i >= 0; i--) begin
            if (!found && v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // ==============================
    // Normalize
    // ==============================

    assign sum_sign = in.acc[WA-1];
    assign mag      = in.acc[MW-1:0];
    assign zero_sum = (mag == '0);
    assign lz       = lzc(mag);
    // Leading one lands on bit MW-1
    assign norm     = mag << lz;
    // Leading one at bit p means value 1.f * 2^(p + bexp - 127)
    assign norm_exp = exp_t'(in.bexp) + exp_t'(MW - 1) - exp_t'(lz);

    // ==============================
    // Round to nearest even
    // ==============================

    assign man        = norm[MW-1 -: MAN_W];
    assign guard_bit  = norm[MW-MAN_W-1];
    assign sticky_bit = |norm[MW-MAN_W-2:0];
    assign round_up   = guard_bit && (sticky_bit || man[0]);
    assign man_rnd    = {1'b0, man} + (MAN_W+1)'(round_up);
    // A carry out leaves 1.000... so the low fraction bits are already zero
    assign carry      = man_rnd[MAN_W];
    assign frac       = man_rnd[MAN_W-2:0];
    assign final_exp  = norm_exp + exp_t'(carry);

    // ==============================
    // Pack and special cases
    // ==============================

    always_comb begin
        if (in.nan) begin
            // Quiet NaN beats infinity
            fp_res = 32'h7FC0_0000;
        end else if (in.inf) begin
            fp_res = {in.inf_sign, 8'hFF, 23'd0};
        end else if (zero_sum || final_exp <= exp_t'(0)) begin
            // Underflow flushes to signed zero
            fp_res = {sum_sign, 31'd0};
        end else if (final_exp >= exp_t'(255)) begin
            fp_res = {sum_sign, 8'hFF, 23'd0};
        end else begin
            fp_res = {sum_sign, final_exp[7:0], frac};
        end
    end

    // Back to two's complement and sign-extend
    assign int_sum = sum_sign ? (~{1'b0, mag} + 1'b1) : {1'b0, mag};
    assign int_res = {{(RES_W-WA){int_sum[WA-1]}}, int_sum};

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            result <= in.is_int ? int_res : fp_res;
        end
    end

    // One-cycle latency holds on the falling edge of the strobe too
    a_valid_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(in.valid) |-> result_valid ##1 !result_valid);

endmodule

//--- fedp_top.f
tcu_norm_pkg.sv
acc_if.sv
fedp_accum.sv
acc_fifo.sv
fedp_norm_round.sv
fedp_top.sv
tb_fedp_top.sv

//--- fedp_top.sv
// Three-cycle latency with stall low and FIFO empty; overflow drops records and stays set
`timescale 1ns/10ps

module fedp_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  tcu_norm_pkg::opnd_t   a0,
    input  tcu_norm_pkg::opnd_t   a1,
    input  tcu_norm_pkg::opnd_t   a2,
    input  tcu_norm_pkg::opnd_t   a3,
    input  tcu_norm_pkg::opnd_t   b0,
    input  tcu_norm_pkg::opnd_t   b1,
    input  tcu_norm_pkg::opnd_t   b2,
    input  tcu_norm_pkg::opnd_t   b3,
    input  tcu_norm_pkg::bexp_t   in_bexp,
    input  logic                  in_is_int,
    input  logic                  in_nan,
    input  logic                  in_inf,
    input  logic                  in_inf_sign,
    input  logic                  stall,
    output logic                  result_valid,
    output tcu_norm_pkg::result_t result,
    output logic                  fifo_overflow
);

    // Producer to buffer, buffer to consumer
    acc_if p2b ();
    acc_if b2c ();

    // Products and exact sum
    fedp_accum u_accum (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .a0          (a0),
        .a1          (a1),
        .a2          (a2),
        .a3          (a3),
        .b0          (b0),
        .b1          (b1),
        .b2          (b2),
        .b3          (b3),
        .in_bexp     (in_bexp),
        .in_is_int   (in_is_int),
        .in_nan      (in_nan),
        .in_inf      (in_inf),
        .in_inf_sign (in_inf_sign),
        .out         (p2b.src)
    );

    // Holds records while stall is high
    acc_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .wr       (p2b.dst),
        .rd       (b2c.src),
        .overflow (fifo_overflow)
    );

    // Normalize, round, pack
    fedp_norm_round u_norm (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (b2c.dst),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

//--- tb_fedp_top.sv
// Reference results come from an integer round-to-nearest-even model; FIFO depth must stay 8
`timescale 1ns/10ps

module tb_fedp_top;
    import tcu_norm_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int N_RAND     = 40;
    localparam int N_INT      = 10;
    localparam int N_FIXED    = 18;
    localparam int N_LAT      = 3;
    // Two stalled bursts of 6 and 10
    localparam int N_REQ      = N_RAND + N_INT + N_FIXED + N_LAT + 6 + 10;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    opnd_t   a [N_PAIRS];
    opnd_t   b [N_PAIRS];
    bexp_t   in_bexp;
    logic    in_is_int;
    logic    in_nan;
    logic    in_inf;
    logic    in_inf_sign;
    logic    stall;
    logic    result_valid;
    result_t result;
    logic    fifo_overflow;

    integer  seed;
    result_t exp_q [$];
    result_t exp_head;
    logic    exp_avail;
    // Cleared for requests that an overrun FIFO will drop
    logic    push_exp;
    logic    lat_on;
    logic    ovf_ok;

    fedp_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .a0            (a[0]),
        .a1            (a[1]),
        .a2            (a[2]),
        .a3            (a[3]),
        .b0            (b[0]),
        .b1            (b[1]),
        .b2            (b[2]),
        .b3            (b[3]),
        .in_bexp       (in_bexp),
        .in_is_int     (in_is_int),
        .in_nan        (in_nan),
        .in_inf        (in_inf),
        .in_inf_sign   (in_inf_sign),
        .stall         (stall),
        .result_valid  (result_valid),
        .result        (result),
        .fifo_overflow (fifo_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // ==============================
    // Reference model
    // ==============================

    // fp32 of s * 2^(bexp-127), nearest even, flush on exponent <= 0
    function automatic result_t expect_fp(input int s, input int bexp);
        logic sgn;
        int   mag;
        int   p;
        int   sh;
        int   q;
        int   rem;
        int   half;
        int   e;
        sgn = (s < 0);
        mag = sgn ? -s : s;
        if (mag == 0) begin
            return {sgn, 31'd0};
        end
        // Position of the leading one
        p = 0;
        while ((mag >> (p + 1)) != 0) begin
            p++;
        end
        if (p <= 23) begin
            q = mag << (23 - p);
        end else begin
            sh   = p - 23;
            q    = mag >> sh;
            rem  = mag & ((1 << sh) - 1);
            half = 1 << (sh - 1);
            if (rem > half || (rem == half && (q % 2) == 1)) begin
                q++;
            end
            // Mantissa wrapped to 2.0
            if (q == (1 << 24)) begin
                q = q >> 1;
                p++;
            end
        end
        e = p + bexp;
        if (e >= 255) begin
            return {sgn, 8'hFF, 23'd0};
        end
        if (e <= 0) begin
            return {sgn, 31'd0};
        end
        return {sgn, e[7:0], q[22:0]};
    endfunction

    // ==============================
    // Stimulus helpers
    // ==============================

    // One request for one cycle, called 1 ns after a rising edge
    task automatic drive_req(input int x0, input int y0, input int x1, input int y1,
                             input int x2, input int y2, input int x3, input int y3,
                             input int bexp, input logic is_int, input logic nan,
                             input logic inf, input logic inf_sign);
        int      s;
        result_t e;
        a[0]        = opnd_t'(x0);
        b[0]        = opnd_t'(y0);
        a[1]        = opnd_t'(x1);
        b[1]        = opnd_t'(y1);
        a[2]        = opnd_t'(x2);
        b[2]        = opnd_t'(y2);
        a[3]        = opnd_t'(x3);
        b[3]        = opnd_t'(y3);
        in_bexp     = bexp_t'(bexp);
        in_is_int   = is_int;
        in_nan      = nan;
        in_inf      = inf;
        in_inf_sign = inf_sign;
        s = x0 * y0 + x1 * y1 + x2 * y2 + x3 * y3;
        if (is_int) begin
            e = result_t'(s);
        end else if (nan) begin
            e = 32'h7FC0_0000;
        end else if (inf) begin
            e = {inf_sign, 8'hFF, 23'd0};
        end else begin
            e = expect_fp(s, bexp);
        end
        if (push_exp) begin
            exp_q.push_back(e);
        end
        in_valid = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Full-range operands, block exponent 100 to 163
    task automatic rand_req(input logic is_int);
        int v [8];
        for (int i = 0; i < 8; i++) begin
            v[i] = $random(seed) % 8192;
        end
        drive_req(v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                  100 + ($random(seed) & 63), is_int, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    // Requests pile up in the FIFO, then stall drops
    task automatic stalled_burst(input int n);
        stall = 1'b1;
        for (int i = 0; i < n; i++) begin
            push_exp = (i < FIFO_DEPTH);
            rand_req(i[0]);
        end
        push_exp = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        stall = 1'b0;
        wait_drain();
    endtask

    // ==============================
    // Result tracking and checks
    // ==============================

    always @(posedge clk) begin
        if (rst_n && result_valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
    end

    // Head settles mid-cycle, steady for the next sampling edge
    always @(negedge clk) begin
        exp_avail <= (exp_q.size() != 0);
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    a_result_expected: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> exp_avail)
        else fail_run("result_valid was high with no request outstanding");

    a_result_match: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && exp_avail |-> result == exp_head)
        else fail_run($sformatf("MISMATCH result got 0x%08h expected 0x%08h",
                                $sampled(result), $sampled(exp_head)));

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        lat_on && in_valid |-> ##1 !result_valid ##1 !result_valid ##1 result_valid)
        else fail_run("result_valid did not follow in_valid by exactly three cycles");

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !ovf_ok |-> !fifo_overflow)
        else fail_run("fifo_overflow rose although the FIFO was never overrun");

    // Watchdog
    initial begin
        repeat (N_REQ * 200 + 1000) @(posedge clk);
        fail_run("Timeout: results stopped arriving before all requests completed");
    end

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        seed        = 35410;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_bexp     = '0;
        in_is_int   = 1'b0;
        in_nan      = 1'b0;
        in_inf      = 1'b0;
        in_inf_sign = 1'b0;
        stall       = 1'b0;
        push_exp    = 1'b1;
        lat_on      = 1'b0;
        ovf_ok      = 1'b0;
        foreach (a[i]) begin
            a[i] = '0;
            b[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < N_RAND; i++) begin
            rand_req(1'b0);
        end
        for (int i = 0; i < N_INT; i++) begin
            rand_req(1'b1);
        end
        // Integer extremes, +2^28 and a large negative
        drive_req(-8192, -8192, -8192, -8192, -8192, -8192, -8192, -8192, 0, 1, 0, 0, 0);
        drive_req(-8192, 8191, -8192, 8191, -8192, 8191, -8192, 8191, 0, 1, 0, 0, 0);
        // Ties at 2^25 + 2 (even, down) and 2^25 + 6 (odd, up), then above half
        drive_req(4096, 4096, 4096, 4096, 2, 1, 0, 0, 127, 0, 0, 0, 0);
        drive_req(4096, 4096, 4096, 4096, 6, 1, 0, 0, 127, 0, 0, 0, 0);
        drive_req(4096, 4096, 4096, 4096, 3, 1, 0, 0, 127, 0, 0, 0, 0);
        drive_req(-4096, 4096, -4096, 4096, -6, 1, 0, 0, 127, 0, 0, 0, 0);
        // 2^26 - 1 rounds into a carry, and into infinity near the top
        drive_req(8191, 8191, 2, 8191, 0, 0, 0, 0, 127, 0, 0, 0, 0);
        drive_req(8191, 8191, 2, 8191, 0, 0, 0, 0, 229, 0, 0, 0, 0);
        // Zero sums
        drive_req(0, 0, 0, 0, 0, 0, 0, 0, 127, 0, 0, 0, 0);
        drive_req(3, 5, -3, 5, 0, 0, 0, 0, 127, 0, 0, 0, 0);
        // Exponent out of range both ways, and the smallest normal
        drive_req(8191, 8191, 0, 0, 0, 0, 0, 0, 250, 0, 0, 0, 0);
        drive_req(-1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        drive_req(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        drive_req(1, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0);
        // Flags, NaN ahead of infinity
        drive_req(5, 7, 0, 0, 0, 0, 0, 0, 127, 0, 1, 0, 0);
        drive_req(5, 7, 0, 0, 0, 0, 0, 0, 127, 0, 0, 1, 1);
        drive_req(-5, 7, 0, 0, 0, 0, 0, 0, 127, 0, 0, 1, 0);
        drive_req(5, 7, 0, 0, 0, 0, 0, 0, 127, 0, 1, 1, 1);
        wait_drain();

        // Isolated requests into an empty FIFO
        lat_on = 1'b1;
        for (int i = 0; i < N_LAT; i++) begin
            rand_req(1'b0);
            repeat (6) @(posedge clk);
            #1;
        end
        lat_on = 1'b0;
        wait_drain();

        stalled_burst(6);
        ovf_ok = 1'b1;
        stalled_burst(10);
        a_ovf_set: assert (fifo_overflow)
            else fail_run("fifo_overflow stayed low after the FIFO was overrun");

        if (exp_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("Expected results were left over after the last request");
        end
    end

endmodule

//--- tcu_norm_pkg.sv
// Widths assume 14-bit signed operands, four pairs per strobe and a 30-bit sign-magnitude sum
package tcu_norm_pkg;

    // ==============================
    // Operand side
    // ==============================

    // Signed integer operand width
    localparam int OPND_W  = 14;
    // Operand pairs summed per request
    localparam int N_PAIRS = 4;
    // Shared block exponent, fp32 bias applies
    localparam int BEXP_W  = 8;

    // ==============================
    // Accumulator and result side
    // ==============================

    // Sign bit plus 29 magnitude bits, enough for 4 * 2^26
    localparam int WA     = 30;
    // Working exponent, wide enough for 255 + 28 + carry
    localparam int EXP_W  = 10;
    // Leading-zero count range over the accumulator
    localparam int LZC_W  = $clog2(WA);
    // fp32 or sign-extended integer word
    localparam int RES_W  = 32;

    typedef logic signed [OPND_W-1:0] opnd_t;
    typedef logic        [BEXP_W-1:0] bexp_t;
    typedef logic        [WA-1:0]     acc_t;
    typedef logic signed [EXP_W-1:0]  exp_t;
    typedef logic        [RES_W-1:0]  result_t;

endpackage
